// ==== testbench/golden_timing.txt ====
# Columns: command, then write <addr> <data> | read <addr> <value> | expect <output> <value>
# Hex addresses, data and values; wait <clocks> in decimal; clock 0 is the reset release
expect VCOUNT 0f8
expect VBLANK 0
expect NVSYNC 0
expect NBNKB 1
expect NIRQ 1
read 3 0000
wait 49
expect HSYNC 1
wait 150
expect HSYNC 0
wait 1335
expect TMS0 0
wait 1
expect TMS0 1
expect VCOUNT 0f9
wait 50
expect HSYNC 1
wait 150
expect HSYNC 0
wait 1336
expect VCOUNT 0fa
expect TMS0 0
wait 9215
expect NVSYNC 0
wait 1
expect NVSYNC 1
write 1 0120
write 0 0001
read 0 0001
wait 49149
expect VCOUNT 120
expect NIRQ 1
wait 1
expect NIRQ 0
read 3 0001
wait 999
write 2 0001
expect NIRQ 0
wait 1
expect NIRQ 1
write 0 0002
wait 318539
expect NBNKB 1
wait 1
expect NBNKB 0
wait 3016
expect VBLANK 1
expect NIRQ 1
wait 1
expect NIRQ 0
read 3 0006
write 2 0002
wait 1
expect NIRQ 1
wait 21500
expect VCOUNT 0f8
wait 12288
expect VBLANK 0
wait 24632
expect NBNKB 1
wait 24521
expect VCOUNT 120
expect NIRQ 1
read 3 0000

// ==== files.f ====
source/videoPkg.sv
source/irqCfgBus.sv
source/videoSync.sv
source/timingRegs.sv
source/rasterIrq.sv
source/videoTimingTop.sv
testbench/clockGen.sv
testbench/videoTimingTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= videoTimingTb
FILELIST ?= files.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert --timescale 1ns/1ns

SIM = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	$(SIM) 2>&1 | tee $(LOG)
	@grep -q "All tests passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== testbench/videoTimingTb.sv ====
`timescale 1ns/1ns

module videoTimingTb;

	localparam int CLK_PERIOD = 40;
	localparam string GOLDEN_FILE = "testbench/golden_timing.txt";

	// DUT ports
	logic CLK_24M;
	logic nRESETP;
	logic cpuSel;
	logic cpuWrite;
	videoPkg::regAddr_t cpuAddr;
	videoPkg::regData_t cpuWriteData;
	videoPkg::regData_t cpuReadData;
	logic TMS0;
	logic VBLANK;
	logic nVSYNC;
	logic HSYNC;
	logic nBNKB;
	videoPkg::vcount_t VCOUNT;
	logic nIRQ;

	// Script, one entry per command line
	string opList[$];
	string nameList[$];
	logic [31:0] argList[$];
	logic [31:0] valueList[$];

	longint waitTotal;
	logic scriptReady;

	clockGen clockGen_i(
		.clk(CLK_24M),
		.nRESETP(nRESETP)
	);

	// Reset line differs from the scripted one, so the line write is visible
	videoTimingTop #(
		.resetRasterLine(9'h110)
	) videoTimingTop_i(
		.CLK_24M(CLK_24M),
		.nRESETP(nRESETP),
		.cpuSel(cpuSel),
		.cpuWrite(cpuWrite),
		.cpuAddr(cpuAddr),
		.cpuWriteData(cpuWriteData),
		.cpuReadData(cpuReadData),
		.TMS0(TMS0),
		.VBLANK(VBLANK),
		.nVSYNC(nVSYNC),
		.HSYNC(HSYNC),
		.nBNKB(nBNKB),
		.VCOUNT(VCOUNT),
		.nIRQ(nIRQ)
	);

	task checkValue(input string what, input logic [31:0] actual, input logic [31:0] expected);
		if (actual !== expected)
		begin
			$display("Mismatch at %0t ns: %s is %0h, expected %0h", $time, what, actual, expected);
			$display("Some tests failed");
			$fatal(1, "Stopped at the first mismatch");
		end
	endtask

	task abortRun(input string reason);
		$display("%s", reason);
		$display("Some tests failed");
		$fatal(1, "Run aborted");
	endtask

	// Whole script up front, so the run length is known before the first clock
	task loadScript;
		int fd;
		int fields;
		int needed;
		string line;
		string op;
		string name;
		logic [31:0] arg;
		logic [31:0] value;
		fd = $fopen(GOLDEN_FILE, "r");
		if (fd == 0)
			abortRun({"Cannot open the golden file ", GOLDEN_FILE});
		waitTotal = 0;
		while ($fgets(line, fd) != 0)
		begin
			fields = $sscanf(line, "%s", op);
			// Blank lines and comments
			if (fields != 1 || op.getc(0) == "#")
				continue;
			name = "";
			arg = '0;
			value = '0;
			needed = 3;
			case (op)
				"wait":
				begin
					fields = $sscanf(line, "%s %d", op, arg);
					needed = 2;
					waitTotal += longint'(arg);
				end
				"write", "read": fields = $sscanf(line, "%s %h %h", op, arg, value);
				"expect": fields = $sscanf(line, "%s %s %h", op, name, value);
				default: abortRun({"Unknown command in the golden file: ", op});
			endcase
			if (fields != needed)
				abortRun({"Missing fields on a golden file line: ", line});
			opList.push_back(op);
			nameList.push_back(name);
			argList.push_back(arg);
			valueList.push_back(value);
		end
		$fclose(fd);
	endtask

	// Output lookup by the name used in the golden file
	task outputValue(input string name, output logic [31:0] value);
		value = '0;
		case (name)
			"VCOUNT": value = {23'd0, VCOUNT};
			"TMS0": value = {31'd0, TMS0};
			"HSYNC": value = {31'd0, HSYNC};
			"VBLANK": value = {31'd0, VBLANK};
			"NVSYNC": value = {31'd0, nVSYNC};
			"NBNKB": value = {31'd0, nBNKB};
			"NIRQ": value = {31'd0, nIRQ};
			default: abortRun({"Unknown output name in the golden file: ", name});
		endcase
	endtask

	// Taken by the DUT at the next rising edge
	task busWrite(input videoPkg::regAddr_t addr, input videoPkg::regData_t data);
		cpuSel = 1'b1;
		cpuWrite = 1'b1;
		cpuAddr = addr;
		cpuWriteData = data;
		@(negedge CLK_24M);
		cpuSel = 1'b0;
		cpuWrite = 1'b0;
	endtask

	// Readback is combinational, sampled a quarter period later
	task busRead(input videoPkg::regAddr_t addr, input videoPkg::regData_t expected);
		cpuSel = 1'b1;
		cpuWrite = 1'b0;
		cpuAddr = addr;
		#(CLK_PERIOD / 4);
		checkValue($sformatf("register %0d readback", addr), {16'd0, cpuReadData},
			{16'd0, expected});
		@(negedge CLK_24M);
		cpuSel = 1'b0;
	endtask

	task runCommand(input int idx);
		logic [31:0] actual;
		case (opList[idx])
			"wait": repeat (argList[idx]) @(negedge CLK_24M);
			"write": busWrite(argList[idx][1:0], valueList[idx][15:0]);
			"read": busRead(argList[idx][1:0], valueList[idx][15:0]);
			default:
			begin
				outputValue(nameList[idx], actual);
				checkValue(nameList[idx], actual, valueList[idx]);
			end
		endcase
	endtask

	initial
	begin
		int cmdIndex;
		cpuSel = 1'b0;
		cpuWrite = 1'b0;
		cpuAddr = '0;
		cpuWriteData = '0;
		scriptReady = 1'b0;
		loadScript();
		scriptReady = 1'b1;
		// Clock count zero is the falling edge that releases reset
		wait (nRESETP === 1'b1);
		for (cmdIndex = 0; cmdIndex < opList.size(); cmdIndex++)
			runCommand(cmdIndex);
		$display("All tests passed");
		$finish;
	end

	// Script waits plus a margin for reset, writes and reads
	initial
	begin
		longint limitNs;
		wait (scriptReady === 1'b1);
		limitNs = (waitTotal + 1000) * longint'(CLK_PERIOD);
		#(limitNs);
		$display("Timeout: the run did not finish within %0d ns", limitNs);
		$display("Some tests failed");
		$fatal(1, "Watchdog expired");
	end

endmodule

// ==== testbench/clockGen.sv ====
`timescale 1ns/1ns

module clockGen(
	output logic clk,
	output logic nRESETP
);

	// Master clock, 40 ns period
	initial
	begin
		clk = 1'b0;
		forever
			#20 clk = ~clk;
	end

	// Low for 16 rising edges
	// Released on a falling edge, away from the DUT sampling edge
	initial
	begin
		nRESETP = 1'b0;
		repeat (16) @(posedge clk);
		@(negedge clk);
		nRESETP = 1'b1;
	end

endmodule

// ==== source/videoTimingTop.sv ====
`timescale 1ns/1ns

module videoTimingTop #(
	parameter videoPkg::vcount_t resetRasterLine = 9'h120
)(
	input logic CLK_24M,
	input logic nRESETP,
	// CPU port
	input logic cpuSel,
	input logic cpuWrite,
	input videoPkg::regAddr_t cpuAddr,
	input videoPkg::regData_t cpuWriteData,
	output videoPkg::regData_t cpuReadData,
	// Video timing
	output logic TMS0,
	output logic VBLANK,
	output logic nVSYNC,
	output logic HSYNC,
	output logic nBNKB,
	output videoPkg::vcount_t VCOUNT,
	output logic nIRQ
);

	// Master position, only needed by the interrupt logic
	videoPkg::mclkCount_t mainCnt;

	// Register to interrupt link
	irqCfgBus cfgBus();

	videoSync videoSync_i(
		.CLK_24M(CLK_24M),
		.nRESETP(nRESETP),
		.mainCnt(mainCnt),
		.vcount(VCOUNT),
		.TMS0(TMS0),
		.vblank(VBLANK),
		.nVSYNC(nVSYNC),
		.HSYNC(HSYNC),
		.nBNKB(nBNKB)
	);

	timingRegs #(
		.resetRasterLine(resetRasterLine)
	) timingRegs_i(
		.CLK_24M(CLK_24M),
		.nRESETP(nRESETP),
		.cpuSel(cpuSel),
		.cpuWrite(cpuWrite),
		.cpuAddr(cpuAddr),
		.cpuWriteData(cpuWriteData),
		.cpuReadData(cpuReadData),
		.vblank(VBLANK),
		.cfg(cfgBus.regs)
	);

	rasterIrq rasterIrq_i(
		.CLK_24M(CLK_24M),
		.nRESETP(nRESETP),
		.mainCnt(mainCnt),
		.vcount(VCOUNT),
		.vblank(VBLANK),
		.cfg(cfgBus.irq),
		.nIRQ(nIRQ)
	);

endmodule

// ==== source/rasterIrq.sv ====
`timescale 1ns/1ns

module rasterIrq(
	input logic CLK_24M,
	input logic nRESETP,
	input videoPkg::mclkCount_t mainCnt,
	input videoPkg::vcount_t vcount,
	input logic vblank,
	irqCfgBus.irq cfg,
	output logic nIRQ
);

	// First clock of either line in the pair
	logic lineStart;

	// Raster compare hit
	logic rasterHit;

	// Blanking edge detect
	logic vblankLast;
	logic vblankRise;

	// Flags
	logic rasterPending;
	logic vblankPending;

	assign lineStart = (mainCnt == 12'd0) || (mainCnt == videoPkg::LINE_MCLK);

	// vcount already holds the new line here
	assign rasterHit = lineStart && cfg.rasterEnable && (vcount == cfg.rasterLine);

	assign vblankRise = vblank & ~vblankLast;

	always_ff @(posedge CLK_24M)
	begin
		if (!nRESETP)
			vblankLast <= 1'b0;
		else
			vblankLast <= vblank;
	end

	// Raster flag
	// A new hit beats an acknowledge on the same clock
	always_ff @(posedge CLK_24M)
	begin
		if (!nRESETP)
			rasterPending <= 1'b0;
		else if (rasterHit)
			rasterPending <= 1'b1;
		else if (cfg.ackRaster)
			rasterPending <= 1'b0;
	end

	// Vertical blank flag
	always_ff @(posedge CLK_24M)
	begin
		if (!nRESETP)
			vblankPending <= 1'b0;
		else if (vblankRise && cfg.vblankEnable)
			vblankPending <= 1'b1;
		else if (cfg.ackVblank)
			vblankPending <= 1'b0;
	end

	assign cfg.rasterPending = rasterPending;
	assign cfg.vblankPending = vblankPending;

	// Active low, any enabled flag
	assign nIRQ = ~((rasterPending & cfg.rasterEnable) | (vblankPending & cfg.vblankEnable));

	// Flags rise only while the matching enable in timingRegs is on
	assert property (@(posedge CLK_24M) disable iff (!nRESETP)
		$rose(rasterPending) |-> $past(cfg.rasterEnable));
	assert property (@(posedge CLK_24M) disable iff (!nRESETP)
		$rose(vblankPending) |-> $past(cfg.vblankEnable));

endmodule

// ==== source/timingRegs.sv ====
`timescale 1ns/1ns

module timingRegs #(
	parameter videoPkg::vcount_t resetRasterLine = 9'h120
)(
	input logic CLK_24M,
	input logic nRESETP,
	input logic cpuSel,
	input logic cpuWrite,
	input videoPkg::regAddr_t cpuAddr,
	input videoPkg::regData_t cpuWriteData,
	output videoPkg::regData_t cpuReadData,
	input logic vblank,
	irqCfgBus.regs cfg
);

	// Write strobe
	logic writeEn;

	// Register contents
	logic rasterEnable;
	logic vblankEnable;
	videoPkg::vcount_t rasterLine;
	logic ackRaster;
	logic ackVblank;

	assign writeEn = cpuSel & cpuWrite;

	// Control and line registers
	always_ff @(posedge CLK_24M)
	begin
		if (!nRESETP)
		begin
			rasterEnable <= 1'b0;
			vblankEnable <= 1'b0;
			rasterLine <= resetRasterLine;
		end
		else if (writeEn)
		begin
			if (cpuAddr == videoPkg::REG_CTRL)
			begin
				rasterEnable <= cpuWriteData[0];
				vblankEnable <= cpuWriteData[1];
			end
			if (cpuAddr == videoPkg::REG_LINE)
				rasterLine <= cpuWriteData[8:0];
		end
	end

	// Acknowledge strobes
	// Write 1 to clear, held for a single clock
	always_ff @(posedge CLK_24M)
	begin
		if (!nRESETP)
		begin
			ackRaster <= 1'b0;
			ackVblank <= 1'b0;
		end
		else
		begin
			ackRaster <= writeEn && (cpuAddr == videoPkg::REG_ACK) && cpuWriteData[0];
			ackVblank <= writeEn && (cpuAddr == videoPkg::REG_ACK) && cpuWriteData[1];
		end
	end

	assign cfg.rasterEnable = rasterEnable;
	assign cfg.vblankEnable = vblankEnable;
	assign cfg.rasterLine = rasterLine;
	assign cfg.ackRaster = ackRaster;
	assign cfg.ackVblank = ackVblank;

	// Readback
	// Bus idles at zero when not selected
	always_comb
	begin
		cpuReadData = 16'h0000;
		if (cpuSel)
		begin
			case (cpuAddr)
				videoPkg::REG_CTRL: cpuReadData = {14'd0, vblankEnable, rasterEnable};
				videoPkg::REG_LINE: cpuReadData = {7'd0, rasterLine};
				// Pending bits, then the blanking level
				videoPkg::REG_STATUS:
					cpuReadData = {13'd0, vblank, cfg.vblankPending, cfg.rasterPending};
				default: cpuReadData = 16'h0000;
			endcase
		end
	end

	// Acknowledge is a strobe, never a level
	assert property (@(posedge CLK_24M) disable iff (!nRESETP)
		(ackRaster || ackVblank) |=> !(ackRaster || ackVblank));

endmodule

// ==== source/videoSync.sv ====
`timescale 1ns/1ns

module videoSync(
	input logic CLK_24M,
	input logic nRESETP,
	output videoPkg::mclkCount_t mainCnt,
	output videoPkg::vcount_t vcount,
	output logic TMS0,
	output logic vblank,
	output logic nVSYNC,
	output logic HSYNC,
	output logic nBNKB
);

	// Position inside the current line
	videoPkg::mclkCount_t linePos;

	// Edges of the pair
	logic midPair;
	logic endPair;

	assign midPair = (mainCnt == videoPkg::LINE_MCLK - 12'd1);
	assign endPair = (mainCnt == videoPkg::PAIR_LAST);

	// Master counter over two lines
	always_ff @(posedge CLK_24M)
	begin
		if (!nRESETP)
			mainCnt <= 12'd0;
		else if (endPair)
			mainCnt <= 12'd0;
		else
			mainCnt <= mainCnt + 12'd1;
	end

	// Line counter
	// Steps at the end of each line, reloads after line 1FF
	always_ff @(posedge CLK_24M)
	begin
		if (!nRESETP)
			vcount <= videoPkg::VCOUNT_FIRST;
		else if (midPair)
			vcount <= vcount + 9'd1;
		else if (endPair)
		begin
			if (vcount == videoPkg::VCOUNT_LAST)
				vcount <= videoPkg::VCOUNT_FIRST;
			else
				vcount <= vcount + 9'd1;
		end
	end

	// Vertical blanking
	// Both edges fall on odd lines, so only the pair end matters
	always_ff @(posedge CLK_24M)
	begin
		if (!nRESETP)
			vblank <= 1'b0;
		else if (endPair)
		begin
			if (vcount == videoPkg::VBLANK_END_LINE)
				vblank <= 1'b0;
			else if (vcount == videoPkg::VBLANK_START_LINE)
				vblank <= 1'b1;
		end
	end

	// Sprite bank blanking
	// Updated a little after the line starts
	always_ff @(posedge CLK_24M)
	begin
		if (!nRESETP)
			nBNKB <= 1'b1;
		else if (mainCnt == videoPkg::BNKB_POS)
		begin
			if (vcount == videoPkg::BNKB_LOW_LINE)
				nBNKB <= 1'b0;
			else if (vcount == videoPkg::BNKB_HIGH_LINE)
				nBNKB <= 1'b1;
		end
	end

	// Second line of the pair
	assign TMS0 = (mainCnt >= videoPkg::LINE_MCLK);

	// Fold the pair back onto one line
	assign linePos = TMS0 ? (mainCnt - videoPkg::LINE_MCLK) : mainCnt;

	// Sync pulse at the head of each line
	assign HSYNC = (linePos <= videoPkg::HSYNC_LAST);

	// Low for lines F8 to FF
	assign nVSYNC = vcount[8];

	// Counter range
	assert property (@(posedge CLK_24M) disable iff (!nRESETP)
		mainCnt <= videoPkg::PAIR_LAST);

	// Frame never runs below the first line
	assert property (@(posedge CLK_24M) disable iff (!nRESETP)
		vcount >= videoPkg::VCOUNT_FIRST);

endmodule

// ==== source/irqCfgBus.sv ====
`timescale 1ns/1ns

interface irqCfgBus;

	// Interrupt enables from the control register
	logic rasterEnable;
	logic vblankEnable;

	// Line that fires the raster interrupt
	videoPkg::vcount_t rasterLine;

	// Single-clock acknowledge strobes
	logic ackRaster;
	logic ackVblank;

	// Pending flags back for status readback
	logic rasterPending;
	logic vblankPending;

	// Register side
	modport regs(
		output rasterEnable, vblankEnable, rasterLine,
		output ackRaster, ackVblank,
		input rasterPending, vblankPending
	);

	// Interrupt side
	modport irq(
		input rasterEnable, vblankEnable, rasterLine,
		input ackRaster, ackVblank,
		output rasterPending, vblankPending
	);

endinterface

// ==== source/videoPkg.sv ====
package videoPkg;

	// Line counter, F8 to 1FF
	typedef logic [8:0] vcount_t;

	// Position within a pair of scanlines
	typedef logic [11:0] mclkCount_t;

	// CPU side
	typedef logic [1:0] regAddr_t;
	typedef logic [15:0] regData_t;

	// Master clocks per scanline
	localparam mclkCount_t LINE_MCLK = 12'd1536;
	// Last count of the two-line pair
	localparam mclkCount_t PAIR_LAST = 12'd3071;

	// Frame limits, 264 lines
	localparam vcount_t VCOUNT_FIRST = 9'h0F8;
	localparam vcount_t VCOUNT_LAST = 9'h1FF;

	// Vertical blanking edges
	localparam vcount_t VBLANK_END_LINE = 9'h0FF;
	localparam vcount_t VBLANK_START_LINE = 9'h1F1;

	// Sprite bank blanking, 14px into the line
	localparam mclkCount_t BNKB_POS = 12'd55;
	localparam vcount_t BNKB_LOW_LINE = 9'h1F0;
	localparam vcount_t BNKB_HIGH_LINE = 9'h110;

	// Last clock of the sync pulse in each line
	localparam mclkCount_t HSYNC_LAST = 12'd110;

	// Register map
	localparam regAddr_t REG_CTRL = 2'd0;
	localparam regAddr_t REG_LINE = 2'd1;
	localparam regAddr_t REG_ACK = 2'd2;
	localparam regAddr_t REG_STATUS = 2'd3;

endpackage
